/* hdmi_tx_config.svh */
`ifndef HDMI_TX_CONFIG_SVH
`define HDMI_TX_CONFIG_SVH

//////////////////////////////
// lane layout

// three data lanes (lane 0 blue, lane 1 green, lane 2 red)
`define TMDS_CHANNELS 3

// bits per colour component
`define TMDS_COLOR_W 8

//////////////////////////////
// symbol timing

`define TMDS_SYMBOL_W 10   // one tmds character

// pclk is the bit clock so one pixel takes one symbol worth of cycles
`define TMDS_SLOTS 10

`define TMDS_SLOT_CNT_W 4  // enough for 0..9

`endif

/* hdmi_tx_pkg.sv */
`default_nettype none

`include "hdmi_tx_config.svh"

package hdmi_tx_pkg;

  //////////////////////////////
  // vector types

  typedef logic [`TMDS_COLOR_W-1:0]  color_t;      // one colour component
  typedef logic [1:0]                ctrl_t;       // {c1, c0}
  typedef logic [`TMDS_SYMBOL_W-1:0] symbol_t;     // one encoded character
  typedef logic signed [3:0]         disparity_t;  // running dc bias

  //////////////////////////////
  // helpers shared by encoder and model

  // fixed characters sent during blanking
  function automatic symbol_t ctrl_symbol(input ctrl_t ctrl);
    symbol_t sym;
    case (ctrl)
      2'b00:   sym = 10'h354;
      2'b01:   sym = 10'h0ab;
      2'b10:   sym = 10'h154;
      default: sym = 10'h2ab;
    endcase
    return sym;
  endfunction

  // population count of one colour byte
  function automatic logic [3:0] ones_count(input color_t value);
    logic [3:0] count;
    count = 4'd0;
    for (int i = 0; i < `TMDS_COLOR_W; i++) begin
      count = count + {3'b000, value[i]};
    end
    return count;
  endfunction

endpackage

`default_nettype wire

/* tmds_pixel_capture.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module tmds_pixel_capture (
  input  logic                                     pclk,
  input  logic                                     SCKclock,
  input  hdmi_tx_pkg::color_t                      red_i,
  input  hdmi_tx_pkg::color_t                      green_i,
  input  hdmi_tx_pkg::color_t                      blue_i,
  input  logic                                     de_i,
  input  logic                                     hsync_i,
  input  logic                                     vsync_i,
  output logic                                     pixel_strobe_o,
  output logic                                     pixel_valid_o,
  output hdmi_tx_pkg::color_t [`TMDS_CHANNELS-1:0] lane_color_o,
  output hdmi_tx_pkg::ctrl_t  [`TMDS_CHANNELS-1:0] lane_ctrl_o,
  output logic                [`TMDS_CHANNELS-1:0] lane_de_o
);

  localparam logic [`TMDS_SLOT_CNT_W-1:0] LAST_SLOT = `TMDS_SLOT_CNT_W'(`TMDS_SLOTS - 1);
  localparam logic [`TMDS_SLOT_CNT_W-1:0] PRE_SLOT  = LAST_SLOT - 1'b1;

  logic [`TMDS_SLOT_CNT_W-1:0]             slot_cnt_q;
  logic                                    strobe_q;
  logic                                    valid_q;
  hdmi_tx_pkg::color_t [`TMDS_CHANNELS-1:0] color_q;
  hdmi_tx_pkg::ctrl_t                      sync_q;   // {vsync, hsync}
  logic                                    de_q;

  //////////////////////////////
  // pixel slot timing

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      slot_cnt_q <= '0;
      strobe_q   <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      slot_cnt_q <= (slot_cnt_q == LAST_SLOT) ? '0 : slot_cnt_q + 1'b1;
      strobe_q   <= (slot_cnt_q == PRE_SLOT);  // high while the count sits at 9
      valid_q    <= strobe_q;                  // one cycle after the sample edge
    end
  end

  //////////////////////////////
  // video word sample

  always_ff @(posedge pclk) begin
    if (strobe_q) begin
      color_q[0] <= blue_i;
      color_q[1] <= green_i;
      color_q[2] <= red_i;
      sync_q     <= {vsync_i, hsync_i};
      de_q       <= de_i;
    end
  end

  // syncs ride on the blue lane only
  assign lane_ctrl_o[0] = sync_q;
  assign lane_ctrl_o[1] = 2'b00;
  assign lane_ctrl_o[2] = 2'b00;

  assign lane_color_o   = color_q;
  assign lane_de_o      = {`TMDS_CHANNELS{de_q}};
  assign pixel_strobe_o = strobe_q;
  assign pixel_valid_o  = valid_q;

endmodule

`default_nettype wire

/* tmds_channel_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module tmds_channel_encoder (
  input  logic                 pclk,
  input  logic                 SCKclock,
  input  hdmi_tx_pkg::color_t  color_i,
  input  hdmi_tx_pkg::ctrl_t   ctrl_i,
  input  logic                 de_i,
  input  logic                 valid_i,
  output hdmi_tx_pkg::symbol_t symbol_o,
  output logic                 symbol_valid_o
);

  logic [3:0]                color_ones;
  logic                      use_xnor;
  logic [`TMDS_COLOR_W:0]    q_m;          // 9-bit intermediate word
  hdmi_tx_pkg::disparity_t   balance;      // ones minus four of q_m[7:0]
  hdmi_tx_pkg::disparity_t   disp_q;
  hdmi_tx_pkg::disparity_t   disp_inc;
  hdmi_tx_pkg::disparity_t   disp_next;
  logic                      sign_eq;
  logic                      zero_case;
  logic                      invert;
  logic                      inc_bias;
  hdmi_tx_pkg::symbol_t      data_symbol;
  hdmi_tx_pkg::symbol_t      symbol_q;
  logic                      valid_q;

  //////////////////////////////
  // transition minimisation

  assign color_ones = hdmi_tx_pkg::ones_count(color_i);

  // xnor when the byte is ones-heavy
  assign use_xnor = (color_ones > 4'd4) || ((color_ones == 4'd4) && !color_i[0]);

  always_comb begin
    q_m[0] = color_i[0];
    for (int i = 1; i < `TMDS_COLOR_W; i++) begin
      q_m[i] = q_m[i-1] ^ color_i[i] ^ use_xnor;
    end
    q_m[`TMDS_COLOR_W] = ~use_xnor;  // records which op was used
  end

  //////////////////////////////
  // dc balance

  assign balance   = $signed(hdmi_tx_pkg::ones_count(q_m[`TMDS_COLOR_W-1:0]) - 4'd4);
  assign sign_eq   = (balance[3] == disp_q[3]);
  assign zero_case = (balance == 4'sd0) || (disp_q == 4'sd0);

  // with no bias either way the q_m[8] flag decides
  assign invert    = zero_case ? ~q_m[`TMDS_COLOR_W] : sign_eq;

  assign inc_bias  = (q_m[`TMDS_COLOR_W] ^ ~sign_eq) & ~zero_case;
  assign disp_inc  = balance - $signed({3'b000, inc_bias});
  assign disp_next = invert ? disp_q - disp_inc : disp_q + disp_inc;

  assign data_symbol = {invert, q_m[`TMDS_COLOR_W],
                        q_m[`TMDS_COLOR_W-1:0] ^ {`TMDS_COLOR_W{invert}}};

  //////////////////////////////
  // symbol register

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      symbol_q <= '0;
      disp_q   <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        if (de_i) begin
          symbol_q <= data_symbol;
          disp_q   <= disp_next;
        end else begin
          symbol_q <= hdmi_tx_pkg::ctrl_symbol(ctrl_i);
          disp_q   <= '0;  // blanking restarts the bias count
        end
      end
    end
  end

  assign symbol_o       = symbol_q;
  assign symbol_valid_o = valid_q;

endmodule

`default_nettype wire

/* tmds_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module tmds_serializer (
  input  logic                                      pclk,
  input  logic                                      SCKclock,
  input  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] symbol_i,
  input  logic                                      load_i,
  output logic                 [`TMDS_CHANNELS-1:0] tmds_data_o,
  output logic                                      tmds_clk_o
);

  // five ones then five zeros, lsb goes out first
  localparam hdmi_tx_pkg::symbol_t CLK_PATTERN = 10'h01f;

  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] data_sr_q;
  hdmi_tx_pkg::symbol_t                      clk_sr_q;

  //////////////////////////////
  // data lanes

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      data_sr_q <= '0;
    end else if (load_i) begin
      data_sr_q <= symbol_i;  // all lanes share the same load phase
    end else begin
      for (int k = 0; k < `TMDS_CHANNELS; k++) begin
        data_sr_q[k] <= data_sr_q[k] >> 1;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < `TMDS_CHANNELS; k++) begin
      tmds_data_o[k] = data_sr_q[k][0];
    end
  end

  //////////////////////////////
  // clock lane

  // reloaded with the data so its rising edge lines up with bit 0
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      clk_sr_q <= '0;
    end else if (load_i) begin
      clk_sr_q <= CLK_PATTERN;
    end else begin
      clk_sr_q <= clk_sr_q >> 1;
    end
  end

  assign tmds_clk_o = clk_sr_q[0];

endmodule

`default_nettype wire

/* hdmi_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module hdmi_tx_top (
  input  logic                        pclk,
  input  logic                        SCKclock,
  input  hdmi_tx_pkg::color_t         red_i,
  input  hdmi_tx_pkg::color_t         green_i,
  input  hdmi_tx_pkg::color_t         blue_i,
  input  logic                        de_i,
  input  logic                        hsync_i,
  input  logic                        vsync_i,
  output logic                        pixel_strobe_o,
  output logic [`TMDS_CHANNELS-1:0]   tmds_data_o,   // 2 red, 1 green, 0 blue
  output logic                        tmds_clk_o
);

  hdmi_tx_pkg::color_t  [`TMDS_CHANNELS-1:0] lane_color;
  hdmi_tx_pkg::ctrl_t   [`TMDS_CHANNELS-1:0] lane_ctrl;
  logic                 [`TMDS_CHANNELS-1:0] lane_de;
  logic                                      pixel_valid;
  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] symbol;
  logic                 [`TMDS_CHANNELS-1:0] symbol_valid;

  //////////////////////////////
  // capture

  tmds_pixel_capture u_capture (
    .pclk           (pclk),
    .SCKclock       (SCKclock),
    .red_i          (red_i),
    .green_i        (green_i),
    .blue_i         (blue_i),
    .de_i           (de_i),
    .hsync_i        (hsync_i),
    .vsync_i        (vsync_i),
    .pixel_strobe_o (pixel_strobe_o),
    .pixel_valid_o  (pixel_valid),
    .lane_color_o   (lane_color),
    .lane_ctrl_o    (lane_ctrl),
    .lane_de_o      (lane_de)
  );

  //////////////////////////////
  // one encoder per lane

  for (genvar k = 0; k < `TMDS_CHANNELS; k++) begin : g_lane
    tmds_channel_encoder u_encoder (
      .pclk           (pclk),
      .SCKclock       (SCKclock),
      .color_i        (lane_color[k]),
      .ctrl_i         (lane_ctrl[k]),
      .de_i           (lane_de[k]),
      .valid_i        (pixel_valid),
      .symbol_o       (symbol[k]),
      .symbol_valid_o (symbol_valid[k])
    );
  end

  //////////////////////////////
  // serial out

  // lanes run in lockstep so lane 0 valid stands for all
  tmds_serializer u_serializer (
    .pclk        (pclk),
    .SCKclock    (SCKclock),
    .symbol_i    (symbol),
    .load_i      (symbol_valid[0]),
    .tmds_data_o (tmds_data_o),
    .tmds_clk_o  (tmds_clk_o)
  );

endmodule

`default_nettype wire

/* hdmi_tx_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module hdmi_tx_properties (
  input logic                      pclk,
  input logic                      SCKclock,
  input logic                      pixel_strobe_i,
  input logic                      pixel_valid_i,
  input logic [`TMDS_CHANNELS-1:0] symbol_valid_i,
  input logic                      tmds_clk_i
);

  logic [3:0] gap_q;   // cycles since the last strobe
  logic       seen_q;
  int         assert_fail_count = 0;

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      gap_q  <= '0;
      seen_q <= 1'b0;
    end else if (pixel_strobe_i) begin
      gap_q  <= '0;
      seen_q <= 1'b1;
    end else if (gap_q != 4'hf) begin
      gap_q <= gap_q + 1'b1;  // saturates
    end
  end

  //////////////////////////////
  // pipeline timing

  a_valid_after_strobe: assert property (@(posedge pclk) disable iff (SCKclock)
    pixel_valid_i == $past(pixel_strobe_i))
    else begin
      $error("pixel_valid does not trail pixel_strobe by one cycle");
      assert_fail_count++;
    end

  a_strobe_recur: assert property (@(posedge pclk) disable iff (SCKclock)
    pixel_strobe_i |-> ##10 pixel_strobe_i)
    else begin
      $error("pixel_strobe did not recur after ten cycles");
      assert_fail_count++;
    end

  a_strobe_gap: assert property (@(posedge pclk) disable iff (SCKclock)
    (seen_q && pixel_strobe_i) |-> (gap_q == 4'd9))
    else begin
      $error("pixel_strobe came early");
      assert_fail_count++;
    end

  a_symbol_after_valid: assert property (@(posedge pclk) disable iff (SCKclock)
    symbol_valid_i == {`TMDS_CHANNELS{$past(pixel_valid_i)}})
    else begin
      $error("symbol_valid does not trail pixel_valid on every lane");
      assert_fail_count++;
    end

  // clock lane high for the first half of each symbol
  a_clock_lane: assert property (@(posedge pclk) disable iff (SCKclock)
    symbol_valid_i[0] |=> tmds_clk_i ##1 tmds_clk_i ##1 tmds_clk_i ##1 tmds_clk_i
                          ##1 tmds_clk_i ##1 !tmds_clk_i)
    else begin
      $error("tmds clock lane is not five cycles high after a load");
      assert_fail_count++;
    end

endmodule

bind hdmi_tx_top hdmi_tx_properties u_properties (
  .pclk           (pclk),
  .SCKclock       (SCKclock),
  .pixel_strobe_i (pixel_strobe_o),
  .pixel_valid_i  (pixel_valid),
  .symbol_valid_i (symbol_valid),
  .tmds_clk_i     (tmds_clk_o)
);

`default_nettype wire

/* hdmi_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdmi_tx_config.svh"

module hdmi_tx_tb;

  localparam int  SEED           = 92965;
  localparam time HALF_PERIOD    = 20ns;   // 40 ns pclk
  localparam int  RESET_CYCLES   = 4;
  localparam int  RANDOM_PIXELS  = 300;
  localparam int  MIXED_PIXELS   = 300;
  localparam int  CLOCK_PIXELS   = 50;
  localparam int  LONG_PIXELS    = 1000;
  localparam int  STROBE_TIMEOUT = 2 * `TMDS_SLOTS;
  localparam int  DRAIN_TIMEOUT  = 4 * `TMDS_SLOTS;

  logic                      pclk;
  logic                      SCKclock;
  hdmi_tx_pkg::color_t       red;
  hdmi_tx_pkg::color_t       green;
  hdmi_tx_pkg::color_t       blue;
  logic                      de;
  logic                      hsync;
  logic                      vsync;
  logic                      pixel_strobe;
  logic [`TMDS_CHANNELS-1:0] tmds_data;
  logic                      tmds_clk;

  int                                        disp_model [`TMDS_CHANNELS];  // in bits, spec form
  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] arm_exp;
  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] col_exp;
  hdmi_tx_pkg::symbol_t [`TMDS_CHANNELS-1:0] rx_sym;
  int          arm_cnt;      // negedges until bit 0 shows up
  logic        col_active;
  int          col_idx;
  int          error_count;
  int          check_count;
  int          test_start_errors;
  int          tests_run;
  int          tests_failed;
  int          prop_fails_seen;
  int unsigned seed_val;
  logic        strobe_seen;

  hdmi_tx_top dut (
    .pclk           (pclk),
    .SCKclock       (SCKclock),
    .red_i          (red),
    .green_i        (green),
    .blue_i         (blue),
    .de_i           (de),
    .hsync_i        (hsync),
    .vsync_i        (vsync),
    .pixel_strobe_o (pixel_strobe),
    .tmds_data_o    (tmds_data),
    .tmds_clk_o     (tmds_clk)
  );

  initial pclk = 1'b0;
  always #HALF_PERIOD pclk = ~pclk;

  //////////////////////////////
  // reference encoder

  // dvi encoder with cnt kept in bits as the spec writes it
  function automatic hdmi_tx_pkg::symbol_t encode_model(input hdmi_tx_pkg::color_t d,
      input hdmi_tx_pkg::ctrl_t ctrl, input logic de_in, inout int cnt);
    logic [8:0] q_m;
    logic       xnor_op;
    int         n1;
    int         n0;
    hdmi_tx_pkg::symbol_t q_out;
    if (!de_in) begin
      cnt = 0;
      return hdmi_tx_pkg::ctrl_symbol(ctrl);
    end
    n1 = hdmi_tx_pkg::ones_count(d);
    xnor_op = (n1 > 4) || ((n1 == 4) && !d[0]);
    q_m[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = xnor_op ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
    end
    q_m[8] = !xnor_op;
    n1 = hdmi_tx_pkg::ones_count(q_m[7:0]);
    n0 = 8 - n1;
    if ((cnt == 0) || (n1 == n0)) begin
      q_out = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
      cnt = q_m[8] ? cnt + n1 - n0 : cnt + n0 - n1;
    end else if (((cnt > 0) && (n1 > n0)) || ((cnt < 0) && (n0 > n1))) begin
      q_out = {1'b1, q_m[8], ~q_m[7:0]};  // pull the bias back
      cnt = cnt + 2 * q_m[8] + n0 - n1;
    end else begin
      q_out = {1'b0, q_m[8], q_m[7:0]};
      cnt = cnt - 2 * (!q_m[8]) + n1 - n0;
    end
    return q_out;
  endfunction

  function automatic hdmi_tx_pkg::color_t rand_color();
    return hdmi_tx_pkg::color_t'($urandom_range(255, 0));
  endfunction

  //////////////////////////////
  // cycle stepping and serial capture

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  // collects one serial bit per falling edge and returns the strobe level
  task automatic step_cycle(output logic strobe_now);
    logic clk_exp;
    @(negedge pclk);
    if (arm_cnt != 0) begin
      arm_cnt = arm_cnt - 1;
      if (arm_cnt == 0) begin
        col_active = 1'b1;
        col_idx    = 0;
        col_exp    = arm_exp;
      end
    end
    if (col_active) begin
      for (int k = 0; k < `TMDS_CHANNELS; k++) begin
        rx_sym[k][col_idx] = tmds_data[k];
      end
      clk_exp = (col_idx < `TMDS_SLOTS / 2);  // five ones then five zeros
      check_count++;
      assert (tmds_clk == clk_exp) else begin
        $display("error tmds_clk_o slot %0d got %h expected %h", col_idx, tmds_clk, clk_exp);
        error_count++;
      end
      col_idx++;
      if (col_idx == `TMDS_SYMBOL_W) begin
        col_active = 1'b0;
        for (int k = 0; k < `TMDS_CHANNELS; k++) begin
          check_count++;
          assert (rx_sym[k] == col_exp[k]) else begin
            $display("error tmds_data_o[%0d] got %h expected %h", k, rx_sym[k], col_exp[k]);
            error_count++;
          end
        end
      end
    end
    strobe_now = pixel_strobe;
  endtask

  task automatic send_pixel(input hdmi_tx_pkg::color_t r, input hdmi_tx_pkg::color_t g,
      input hdmi_tx_pkg::color_t b, input logic de_in, input logic hs, input logic vs);
    logic strobe_now;
    int   waited;
    waited     = 0;
    strobe_now = 1'b0;
    while (!strobe_now) begin
      if (waited >= STROBE_TIMEOUT) begin
        stop_on_timeout("pixel_strobe_o never came");
      end else begin
        step_cycle(strobe_now);
        waited++;
      end
    end
    red   = r;  // held across the sampling edge
    green = g;
    blue  = b;
    de    = de_in;
    hsync = hs;
    vsync = vs;
    arm_exp[0] = encode_model(b, {vs, hs}, de_in, disp_model[0]);
    arm_exp[1] = encode_model(g, 2'b00, de_in, disp_model[1]);
    arm_exp[2] = encode_model(r, 2'b00, de_in, disp_model[2]);
    arm_cnt    = 3;
  endtask

  // a blanking pixel brings both sides back to zero disparity before the last bit drains
  task automatic drain_pipeline();
    logic strobe_now;
    int   waited;
    send_pixel('0, '0, '0, 1'b0, 1'b0, 1'b0);
    waited = 0;
    while (col_active || (arm_cnt != 0)) begin
      if (waited >= DRAIN_TIMEOUT) begin
        stop_on_timeout("serial output of the last pixel never finished");
      end else begin
        step_cycle(strobe_now);
        waited++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    int prop_fails;
    prop_fails = dut.u_properties.assert_fail_count;
    error_count += prop_fails - prop_fails_seen;  // bound timing checks
    prop_fails_seen = prop_fails;
    tests_run++;
    if (error_count == test_start_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    seed_val = $urandom(SEED);
    SCKclock = 1'b1;
    red = '0;
    green = '0;
    blue = '0;
    de = 1'b0;
    hsync = 1'b0;
    vsync = 1'b0;
    arm_cnt = 0;
    col_active = 1'b0;
    col_idx = 0;
    error_count = 0;
    check_count = 0;
    test_start_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    prop_fails_seen = 0;
    strobe_seen = 1'b0;
    for (int k = 0; k < `TMDS_CHANNELS; k++) begin
      disp_model[k] = 0;
    end

    repeat (RESET_CYCLES) begin
      @(negedge pclk);
      check_count++;
      assert ({tmds_data, tmds_clk, pixel_strobe} == '0) else begin
        $display("error during reset tmds_data_o %h tmds_clk_o %h pixel_strobe_o %h expected 0",
                 tmds_data, tmds_clk, pixel_strobe);
        error_count++;
      end
    end
    SCKclock = 1'b0;
    // serial lines stay quiet until the first symbol is loaded
    for (int w = 0; !strobe_seen; w++) begin
      if (w >= STROBE_TIMEOUT) begin
        stop_on_timeout("no pixel_strobe_o after reset");
      end else begin
        step_cycle(strobe_seen);
        check_count++;
        assert ({tmds_data, tmds_clk} == '0) else begin
          $display("error after reset got tmds_data_o %h tmds_clk_o %h expected 0",
                   tmds_data, tmds_clk);
          error_count++;
        end
      end
    end
    finish_test("reset state");

    for (int c = 0; c < 4; c++) begin
      send_pixel(rand_color(), rand_color(), rand_color(), 1'b0, c[0], c[1]);
    end
    drain_pipeline();
    finish_test("control periods");

    for (int p = 0; p < RANDOM_PIXELS; p++) begin
      send_pixel(rand_color(), rand_color(), rand_color(), 1'b1, 1'b0, 1'b0);
    end
    drain_pipeline();
    finish_test("random active video");

    for (int p = 0; p < MIXED_PIXELS; p++) begin
      send_pixel(rand_color(), rand_color(), rand_color(), ($urandom_range(3, 0) != 0),
                 1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
    end
    drain_pipeline();
    finish_test("mixed blanking and active");

    // clock lane alignment with de toggling at random
    for (int p = 0; p < CLOCK_PIXELS; p++) begin
      send_pixel(rand_color(), rand_color(), rand_color(), 1'($urandom_range(1, 0)),
                 1'b0, 1'b0);
    end
    drain_pipeline();
    finish_test("clock lane");

    for (int p = 0; p < LONG_PIXELS; p++) begin
      send_pixel(rand_color(), rand_color(), rand_color(), 1'b1, 1'b0, 1'b0);
      for (int k = 0; k < `TMDS_CHANNELS; k++) begin
        check_count++;
        assert ((disp_model[k] / 2 >= -8) && (disp_model[k] / 2 <= 7)) else begin
          $display("model disparity on lane %0d left the 4-bit signed range", k);
          error_count++;
        end
      end
    end
    drain_pipeline();
    finish_test("dc balance");

    $display("tests %0d, with errors %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdmi_tx.f */
+incdir+.
hdmi_tx_pkg.sv
tmds_pixel_capture.sv
tmds_channel_encoder.sv
tmds_serializer.sv
hdmi_tx_top.sv
hdmi_tx_properties.sv
hdmi_tx_tb.sv

/* Bender.yml */
package:
  name: hdmi_tx

export_include_dirs:
  - .

sources:
  - files:
      - hdmi_tx_pkg.sv
      - tmds_pixel_capture.sv
      - tmds_channel_encoder.sv
      - tmds_serializer.sv
      - hdmi_tx_top.sv
  - target: test
    files:
      - hdmi_tx_properties.sv
      - hdmi_tx_tb.sv
